// File: design/spu_pkg.sv
package spu_pkg;

    // ----------------------------------------
    //  lane geometry
    // ----------------------------------------

    localparam int LANES     = 8;                   // lanes per vector
    localparam int LANE_BITS = 8;                   // bits per lane
    localparam int VEC_BITS  = LANES * LANE_BITS;   // full vector width

    typedef logic [LANE_BITS-1:0] lane_t;

    // lane 0 sits in bits [LANE_BITS-1:0]
    typedef lane_t [LANES-1:0] vec_t;


    // ----------------------------------------
    //  lane operations
    // ----------------------------------------

    typedef enum logic {
        OP_ADD = 1'b0,  // a + b
        OP_SUB = 1'b1   // a - b
    } alu_op_e;


    // ----------------------------------------
    //  stage 0 immediates
    // ----------------------------------------

    localparam lane_t IMM_A = lane_t'(2);   // added to each lane of a
    localparam lane_t IMM_B = lane_t'(1);   // added to each lane of b


    // ----------------------------------------
    //  default stage latencies
    // ----------------------------------------

    // cke-enabled cycles per stage
    localparam int DEF_ADD_LATENCY = 1;
    localparam int DEF_SUB_LATENCY = 1;

endpackage

// File: design/spu_lane_alu.sv
`timescale 1ns/1ps

module spu_lane_alu
    import spu_pkg::*;
    #(
        parameter alu_op_e OP      = OP_ADD,   // lane operation
        parameter int      LATENCY = 1         // register stages, at least 1
    )
    (
        input  var logic    clk,
        input  var logic    reset,
        input  var logic    cke,     // clock enable

        input  var lane_t   a,
        input  var lane_t   b,

        output var lane_t   y
    );


    // ----------------------------------------
    //  operation
    // ----------------------------------------

    lane_t result;

    always_comb begin
        unique case (OP)
            OP_ADD:  result = a + b;   // wraps mod 2**LANE_BITS
            OP_SUB:  result = a - b;
            default: result = a + b;
        endcase
    end


    // ----------------------------------------
    //  latency chain
    // ----------------------------------------

    lane_t pipe [LATENCY];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                pipe[i] <= '0;
            end
        end
        else if (cke) begin
            pipe[0] <= result;
            for (int i = 1; i < LATENCY; i++) begin
                pipe[i] <= pipe[i-1];   // shift toward output
            end
        end
    end

    assign y = pipe[LATENCY-1];


    // ----------------------------------------
    //  checks
    // ----------------------------------------

    // a disabled edge must leave the result untouched
    a_hold_on_stall : assert property (
        @(posedge clk) (!cke && !reset) |=> $stable(y)
    )
    else $error("spu_lane_alu: y changed while cke low");

endmodule

// File: design/spu_imm_stage.sv
`timescale 1ns/1ps

module spu_imm_stage
    import spu_pkg::*;
    #(
        parameter int LATENCY = DEF_ADD_LATENCY   // enabled cycles through the stage
    )
    (
        input  var logic    clk,
        input  var logic    reset,
        input  var logic    cke,        // clock enable

        input  var vec_t    s_data0,    // a
        input  var vec_t    s_data1,    // b
        input  var logic    s_valid,

        output var vec_t    m_data0,    // a + IMM_A
        output var vec_t    m_data1,    // IMM_B + b
        output var logic    m_valid
    );


    // ----------------------------------------
    //  per-lane immediate add
    // ----------------------------------------

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        spu_lane_alu
            #(
                .OP         (OP_ADD),
                .LATENCY    (LATENCY)
            )
            u_add_a
            (
                .clk        (clk),
                .reset      (reset),
                .cke        (cke),
                .a          (s_data0[i]),
                .b          (IMM_A),
                .y          (m_data0[i])
            );

        spu_lane_alu
            #(
                .OP         (OP_ADD),
                .LATENCY    (LATENCY)
            )
            u_add_b
            (
                .clk        (clk),
                .reset      (reset),
                .cke        (cke),
                .a          (IMM_B),        // immediate first, as 1 + b
                .b          (s_data1[i]),
                .y          (m_data1[i])
            );
    end


    // ----------------------------------------
    //  valid delay line
    // ----------------------------------------

    logic valid_pipe [LATENCY];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end
        else if (cke) begin
            valid_pipe[0] <= s_valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign m_valid = valid_pipe[LATENCY-1];   // aligned with lane results


    // ----------------------------------------
    //  checks
    // ----------------------------------------

    a_valid_cleared : assert property (
        @(posedge clk) reset |=> !m_valid
    )
    else $error("spu_imm_stage: m_valid high after reset");

endmodule

// File: design/spu_diff_stage.sv
`timescale 1ns/1ps

module spu_diff_stage
    import spu_pkg::*;
    #(
        parameter int LATENCY = DEF_SUB_LATENCY   // enabled cycles through the stage
    )
    (
        input  var logic    clk,
        input  var logic    reset,
        input  var logic    cke,        // clock enable

        input  var vec_t    s_data0,    // minuend
        input  var vec_t    s_data1,    // subtrahend
        input  var logic    s_valid,

        output var vec_t    m_data,     // s_data0 - s_data1 per lane
        output var logic    m_valid
    );


    // ----------------------------------------
    //  per-lane subtract
    // ----------------------------------------

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        spu_lane_alu
            #(
                .OP         (OP_SUB),
                .LATENCY    (LATENCY)
            )
            u_sub
            (
                .clk        (clk),
                .reset      (reset),
                .cke        (cke),
                .a          (s_data0[i]),
                .b          (s_data1[i]),
                .y          (m_data[i])
            );
    end


    // ----------------------------------------
    //  valid delay line
    // ----------------------------------------

    // this register chain doubles as the hand-off buffer
    // between producer and consumer
    logic valid_pipe [LATENCY];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end
        else if (cke) begin
            valid_pipe[0] <= s_valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign m_valid = valid_pipe[LATENCY-1];


    // ----------------------------------------
    //  checks
    // ----------------------------------------

    // stalled pipeline keeps its output beat
    a_valid_hold : assert property (
        @(posedge clk) (!cke && !reset) |=> $stable(m_valid)
    )
    else $error("spu_diff_stage: m_valid changed while cke low");

endmodule

// File: design/stream_processing_unit.sv
`timescale 1ns/1ps

module stream_processing_unit
    import spu_pkg::*;
    #(
        parameter int ADD_LATENCY = DEF_ADD_LATENCY,   // stage 0
        parameter int SUB_LATENCY = DEF_SUB_LATENCY    // stage 1
    )
    (
        // system
        input  var logic    clk,
        input  var logic    reset,
        input  var logic    cke,        // freezes the whole pipeline when low

        // input beat
        input  var vec_t    s_data0,    // a
        input  var vec_t    s_data1,    // b
        input  var logic    s_valid,

        // output beat
        output var vec_t    m_data0,    // a - b + 1 per lane
        output var vec_t    m_data1,    // always zero
        output var logic    m_valid
    );


    // ----------------------------------------
    //  stage 0: a + 2, 1 + b
    // ----------------------------------------

    vec_t stage0_data0;
    vec_t stage0_data1;
    logic stage0_valid;

    spu_imm_stage
        #(
            .LATENCY    (ADD_LATENCY)
        )
        u_imm_stage
        (
            .clk        (clk),
            .reset      (reset),
            .cke        (cke),
            .s_data0    (s_data0),
            .s_data1    (s_data1),
            .s_valid    (s_valid),
            .m_data0    (stage0_data0),
            .m_data1    (stage0_data1),
            .m_valid    (stage0_valid)
        );


    // ----------------------------------------
    //  stage 1: difference
    // ----------------------------------------

    spu_diff_stage
        #(
            .LATENCY    (SUB_LATENCY)
        )
        u_diff_stage
        (
            .clk        (clk),
            .reset      (reset),
            .cke        (cke),
            .s_data0    (stage0_data0),
            .s_data1    (stage0_data1),
            .s_valid    (stage0_valid),
            .m_data     (m_data0),
            .m_valid    (m_valid)
        );


    // ----------------------------------------
    //  second output
    // ----------------------------------------

    assign m_data1 = '0;   // no datapath behind it

endmodule

// File: testbench/tb_stream_processing_unit.sv
`timescale 1ns/1ps

module tb_stream_processing_unit
    import spu_pkg::*;
    ();

    localparam int RANDOM_BEATS = 300;
    localparam int DRAIN_LIMIT  = 20;   // cycles allowed to empty the pipeline

    logic clk;
    logic reset;
    logic cke;
    vec_t s_data0;
    vec_t s_data1;
    logic s_valid;
    vec_t m_data0;
    vec_t m_data1;
    logic m_valid;

    int          fail_count = 0;
    int          in_count   = 0;
    int          out_count  = 0;
    logic [31:0] lcg_state  = 32'hb02d89c2;

    vec_t model_data  [2];   // two enabled edges deep
    logic model_valid [2];

    stream_processing_unit dut0 (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .s_data0 (s_data0),
        .s_data1 (s_data1),
        .s_valid (s_valid),
        .m_data0 (m_data0),
        .m_data1 (m_data1),
        .m_valid (m_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    //  helpers
    // ----------------------------------------

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic vec_t random_vec();
        vec_t        v;
        logic [31:0] r;
        for (int i = 0; i < LANES; i++) begin
            r    = next_rand();
            v[i] = r[23:16];
        end
        return v;
    endfunction

    function automatic vec_t splat(input lane_t value);
        vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = value;
        end
        return v;
    endfunction

    // a - b + 1 in every lane, mod 256
    function automatic vec_t expected_vec(input vec_t a, input vec_t b);
        vec_t r;
        for (int i = 0; i < LANES; i++) begin
            r[i] = a[i] - b[i] + lane_t'(1);
        end
        return r;
    endfunction

    task automatic drive_cycle(input logic en, input logic valid, input vec_t a, input vec_t b);
        @(posedge clk);
        #0.5;
        cke     = en;
        s_valid = valid;
        s_data0 = a;
        s_data1 = b;
    endtask

    // ----------------------------------------
    //  reference model and beat counts
    // ----------------------------------------

    always @(posedge clk) begin
        if (reset) begin
            model_data[0]  <= '0;
            model_data[1]  <= '0;
            model_valid[0] <= 1'b0;
            model_valid[1] <= 1'b0;
            in_count       <= 0;   // beats in flight are dropped
            out_count      <= 0;
        end
        else if (cke) begin
            model_data[0]  <= expected_vec(s_data0, s_data1);
            model_data[1]  <= model_data[0];
            model_valid[0] <= s_valid;
            model_valid[1] <= model_valid[0];
            if (s_valid) in_count <= in_count + 1;
            if (m_valid) out_count <= out_count + 1;   // beat leaves on this edge
        end
    end

    // ----------------------------------------
    //  checks
    // ----------------------------------------

    a_reset_clear : assert property (
        @(posedge clk) reset |=> (!m_valid && m_data0 == '0)
    )
    else begin
        fail_count = fail_count + 1;
        $display("[FAIL] %0t: output not cleared by reset", $time);
    end

    a_valid_match : assert property (
        @(posedge clk) !reset |-> (m_valid == model_valid[1])
    )
    else begin
        fail_count = fail_count + 1;
        $display("[FAIL] %0t: m_valid %b, expected %b", $time,
                 $sampled(m_valid), $sampled(model_valid[1]));
    end

    a_data_match : assert property (
        @(posedge clk) (!reset && m_valid) |-> (m_data0 == model_data[1])
    )
    else begin
        fail_count = fail_count + 1;
        $display("[FAIL] %0t: m_data0 %h, expected %h", $time,
                 $sampled(m_data0), $sampled(model_data[1]));
    end

    a_data1_zero : assert property (
        @(posedge clk) m_data1 == '0
    )
    else begin
        fail_count = fail_count + 1;
        $display("[FAIL] %0t: m_data1 %h, expected zero", $time, $sampled(m_data1));
    end

    a_stall_hold : assert property (
        @(posedge clk) (!cke && !reset) |=> ($stable(m_data0) && $stable(m_valid))
    )
    else begin
        fail_count = fail_count + 1;
        $display("[FAIL] %0t: output moved during a stall", $time);
    end

    // ----------------------------------------
    //  stimulus
    // ----------------------------------------

    initial begin
        logic [31:0] r;
        int          stall_len;
        int          waited;

        reset   = 1'b1;
        cke     = 1'b0;   // reset must work with the pipeline frozen
        s_valid = 1'b0;
        s_data0 = '0;
        s_data1 = '0;
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;
        cke   = 1'b1;

        drive_cycle(1'b1, 1'b0, '0, '0);
        drive_cycle(1'b1, 1'b0, '0, '0);

        // wrap corners and equal lanes
        drive_cycle(1'b1, 1'b1, splat(8'd0), splat(8'd255));
        drive_cycle(1'b1, 1'b1, splat(8'd255), splat(8'd0));
        drive_cycle(1'b1, 1'b1, splat(8'd77), splat(8'd77));
        drive_cycle(1'b1, 1'b1, vec_t'(64'h00_ff_80_07_ff_00_63_01),
                    vec_t'(64'hff_00_80_08_00_ff_63_01));
        drive_cycle(1'b1, 1'b0, random_vec(), random_vec());
        drive_cycle(1'b1, 1'b1, random_vec(), random_vec());

        // stall with inputs wiggling underneath
        for (int i = 0; i < 3; i++) begin
            drive_cycle(1'b0, 1'b1, random_vec(), random_vec());
        end
        drive_cycle(1'b1, 1'b1, random_vec(), random_vec());
        drive_cycle(1'b0, 1'b0, random_vec(), random_vec());
        drive_cycle(1'b1, 1'b1, random_vec(), random_vec());

        // reset again with beats in flight and the pipeline frozen
        @(posedge clk);
        #0.5;
        reset = 1'b1;
        cke   = 1'b0;
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;
        cke   = 1'b1;

        for (int n = 0; n < RANDOM_BEATS; n++) begin
            r = next_rand();
            if (r[7:0] < 8'd40) begin
                stall_len = 1 + int'(r[9:8]);
                for (int k = 0; k < stall_len; k++) begin
                    drive_cycle(1'b0, r[k+10], random_vec(), random_vec());
                end
            end
            drive_cycle(1'b1, (r[23:16] < 8'd192), random_vec(), random_vec());
        end

        // drain until the model holds no beat and none is waiting at the input
        waited = 0;
        while ((s_valid || model_valid[0] || model_valid[1]) && waited < DRAIN_LIMIT) begin
            drive_cycle(1'b1, 1'b0, '0, '0);
            waited++;
        end

        if (waited >= DRAIN_LIMIT) begin
            $display("timeout: pipeline still held beats after %0d drain cycles", DRAIN_LIMIT);
            $display("sim failed");
            $finish;
        end
        else begin
            assert (in_count == out_count)
            else begin
                fail_count = fail_count + 1;
                $display("[FAIL] %0t: %0d valid beats in, %0d out", $time,
                         in_count, out_count);
            end
            repeat (3) drive_cycle(1'b1, 1'b0, '0, '0);
            $display("errors: %0d check failures, %0d beats in, %0d beats out",
                     fail_count, in_count, out_count);
            if (fail_count == 0) begin
                $display("sim passed");
            end
            else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

// File: stream_processing_unit.f
design/spu_pkg.sv
design/spu_lane_alu.sv
design/spu_imm_stage.sv
design/spu_diff_stage.sv
design/stream_processing_unit.sv
testbench/tb_stream_processing_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the stream processing unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_stream_processing_unit \
    -f stream_processing_unit.f \
    -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    echo "testbench reported failure"
    exit 1
fi

echo "testbench reported no failure"
